// ==== src.f ====
common/ciPkg.sv
common/ciUnitIf.sv
design/resetSequencer.sv
design/ciDispatcher.sv
design/pixelUnit.sv
design/delayUnit.sv
design/profileUnit.sv
design/ciSystem.sv
tb/tbClock.sv
tb/ciSystem_chk.sv
tb/ciSystemTb.sv

// ==== Makefile ====
# Verilator build and run for the custom-instruction system testbench.

VERILATOR ?= verilator
TOP       ?= ciSystemTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^sim passed$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/ciSystemTb.sv ====
`timescale 1ns/10ps

module ciSystemTb;

  localparam int resetCycles   = 16;
  localparam int delayWidth    = 16;
  localparam int NumInstr      = 200;
  localparam int DelayCap      = 63;
  localparam int TimeoutCycles = NumInstr * (DelayCap + 10) + 100;

  logic             s_systemClock;
  logic             s_pllLocked;
  logic             ciReq;
  ciPkg::ciNumber_t ciN;
  ciPkg::ciWord_t   ciDataA;
  ciPkg::ciWord_t   ciDataB;
  logic             ciAck;
  ciPkg::ciWord_t   ciResult;
  logic             systemReady;

  int          cycleCount = 0; // rising edges since the start of the run.
  logic [31:0] lfsrState  = 32'hb180_b275;

  tbClock #(.periodNs(100), .lockCycles(2)) i_tbClock (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked)
  );

  ciSystem #(
    .resetCycles(resetCycles),
    .delayWidth (delayWidth)
  ) i_ciSystem (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .ciReq        (ciReq),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDataB      (ciDataB),
    .ciAck        (ciAck),
    .ciResult     (ciResult),
    .systemReady  (systemReady)
  );

  always @(posedge s_systemClock) cycleCount <= cycleCount + 1;

  function automatic logic [31:0] nextLfsr(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  function automatic ciPkg::ciWord_t takeBits(input int count);
    ciPkg::ciWord_t value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = nextLfsr(lfsrState);
      value     = {value[30:0], lfsrState[0]};
    end
    return value;
  endfunction

  // weighted sum of one RGB565 pixel, each field first widened to 8 bits.
  function automatic logic [7:0] grayOf(input logic [15:0] pixel);
    int red;
    int green;
    int blue;
    int sum;
    red   = int'(pixel[15:11]) * 8;
    green = int'(pixel[10:5]) * 4;
    blue  = int'(pixel[4:0]) * 8;
    sum   = red * int'(ciPkg::GrayRedWeight) + green * int'(ciPkg::GrayGreenWeight)
          + blue * int'(ciPkg::GrayBlueWeight);
    return sum[15:8];
  endfunction

  task automatic abortRun(input string message);
    $display("%s", message);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic checkWord(input ciPkg::ciWord_t actual, input ciPkg::ciWord_t expected,
                           input string what);
    if (actual !== expected) begin
      abortRun($sformatf("[FAIL] %0t ns %s: got %h, expected %h", $time, what, actual,
                         expected));
    end
  endtask

  task automatic checkAtLeast(input ciPkg::ciWord_t actual, input ciPkg::ciWord_t bound,
                              input string what);
    if (actual < bound) begin
      abortRun($sformatf("[FAIL] %0t ns %s: got %0d, expected at least %0d", $time, what,
                         actual, bound));
    end
  endtask

  task automatic checkReady(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      abortRun($sformatf("[FAIL] %0t ns %s: got %b, expected %b", $time, what, actual,
                         expected));
    end
  endtask

  // one four-phase transfer. It is entered and left on a falling edge.
  task automatic runInstruction(input ciPkg::ciNumber_t number, input ciPkg::ciWord_t a,
                                input ciPkg::ciWord_t b, output ciPkg::ciWord_t result,
                                output int latency, output int sampleCycle);
    ciN         = number;
    ciDataA     = a;
    ciDataB     = b;
    ciReq       = 1'b1;
    sampleCycle = cycleCount + 1; // the next rising edge samples the request.
    do @(negedge s_systemClock); while (!ciAck);
    latency = cycleCount - sampleCycle; // cycles from the sampling edge to the ack edge.
    result  = ciResult;
    ciReq   = 1'b0;
    do @(negedge s_systemClock); while (ciAck);
  endtask

  initial begin
    wait (cycleCount >= TimeoutCycles);
    abortRun($sformatf("timeout: the run did not end within %0d clock cycles", TimeoutCycles));
  end

  initial begin
    int               edgeIndex;
    int               sel;
    int               gap;
    int               latency;
    int               sampleCycle;
    int               clearSample;
    int               delayCycles;
    logic             hasClear;
    ciPkg::ciNumber_t number;
    ciPkg::ciWord_t   a;
    ciPkg::ciWord_t   b;
    ciPkg::ciWord_t   result;
    ciPkg::ciWord_t   lastRead;

    ciReq       = 1'b0;
    ciN         = '0;
    ciDataA     = '0;
    ciDataB     = '0;
    hasClear    = 1'b0;
    clearSample = 0;
    lastRead    = '0;

    @(posedge s_systemClock);
    @(negedge s_systemClock);
    checkReady(systemReady, 1'b0, "systemReady before lock");
    @(posedge s_pllLocked);
    for (edgeIndex = 1; edgeIndex <= resetCycles; edgeIndex++) begin
      @(posedge s_systemClock);
      @(negedge s_systemClock);
      checkReady(systemReady, edgeIndex == resetCycles, "systemReady after lock");
      checkReady(ciAck, 1'b0, "ciAck during reset");
    end

    for (int index = 0; index < NumInstr; index++) begin
      gap = int'(takeBits(2));
      repeat (gap) @(negedge s_systemClock);
      sel = int'(takeBits(3));
      a   = takeBits(32);
      b   = takeBits(32);
      case (sel)
        0, 1: begin
          runInstruction(ciPkg::CiSwapByte, a, b, result, latency, sampleCycle);
          checkWord(result, {a[7:0], a[15:8], a[23:16], a[31:24]}, "byte swap");
        end
        2, 3: begin
          runInstruction(ciPkg::CiGrayscale, a, b, result, latency, sampleCycle);
          checkWord(result, {16'h0000, grayOf(a[31:16]), grayOf(a[15:0])}, "grayscale");
        end
        4: begin
          delayCycles = int'(takeBits(6));
          a[delayWidth-1:0] = delayWidth'(delayCycles);
          runInstruction(ciPkg::CiDelay, a, b, result, latency, sampleCycle);
          checkWord(result, '0, "delay result");
          checkAtLeast(ciPkg::ciWord_t'(latency), ciPkg::ciWord_t'(delayCycles + 1),
                       "delay latency");
        end
        5: begin
          runInstruction(ciPkg::CiProfile, a, b, result, latency, sampleCycle);
          checkAtLeast(result, lastRead, "profile count order");
          if (hasClear) begin
            // the count restarts on the edge after the clearing request is sampled.
            checkAtLeast(result, ciPkg::ciWord_t'(sampleCycle - clearSample - 1),
                         "profile count since clear");
            checkAtLeast(ciPkg::ciWord_t'(sampleCycle - clearSample), result,
                         "profile restart bound");
          end
          if (b[0]) begin
            lastRead    = '0;
            clearSample = sampleCycle;
            hasClear    = 1'b1;
          end else begin
            lastRead = result;
          end
        end
        default: begin
          number = ciPkg::ciNumber_t'(takeBits(8));
          if (number == ciPkg::CiSwapByte || number == ciPkg::CiDelay ||
              number == ciPkg::CiGrayscale || number == ciPkg::CiProfile) begin
            number = number ^ 8'h80; // moves it off every used number.
          end
          runInstruction(number, a, b, result, latency, sampleCycle);
          checkWord(result, '0, "unknown instruction");
        end
      endcase
    end

    $display("sim passed");
    $finish;
  end

endmodule

// ==== tb/ciSystem_chk.sv ====
`timescale 1ns/10ps

module ciSystemChk (
  input logic           s_systemClock,
  input logic           systemReady,
  input logic           ciReq,
  input logic           ciAck,
  input ciPkg::ciWord_t ciResult
);

  // an acknowledge always answers a request that was high on the edge before.
  ackNeedsReq: assert property (@(posedge s_systemClock) disable iff (!systemReady)
    $rose(ciAck) |-> $past(ciReq))
    else $error("ciAck rose while ciReq was low.");

  resultHeld: assert property (@(posedge s_systemClock) disable iff (!systemReady)
    (ciAck && $past(ciAck)) |-> $stable(ciResult))
    else $error("ciResult changed while ciAck was high.");

  // ciReq low is seen on one edge and ciAck drops on the edge after it.
  ackReleased: assert property (@(posedge s_systemClock) disable iff (!systemReady)
    $fell(ciReq) |-> ##2 !ciAck)
    else $error("ciAck still high two cycles after ciReq fell.");

endmodule

bind ciSystem ciSystemChk i_ciSystemChk (
  .s_systemClock(s_systemClock),
  .systemReady  (systemReady),
  .ciReq        (ciReq),
  .ciAck        (ciAck),
  .ciResult     (ciResult)
);

// ==== tb/tbClock.sv ====
`timescale 1ns/10ps

module tbClock #(
  parameter int periodNs   = 100,
  parameter int lockCycles = 2
) (
  output logic s_systemClock,
  output logic s_pllLocked
);

  initial begin
    s_systemClock = 1'b0;
    forever #(periodNs / 2) s_systemClock = ~s_systemClock;
  end

  // lock is reported on a falling edge, like every other input of the DUT.
  initial begin
    s_pllLocked = 1'b0;
    repeat (lockCycles) @(posedge s_systemClock);
    @(negedge s_systemClock);
    s_pllLocked = 1'b1;
  end

endmodule

// ==== design/ciSystem.sv ====
`timescale 1ns/10ps

module ciSystem #(
  parameter int resetCycles = 16,
  parameter int delayWidth  = 16
) (
  input  logic             s_systemClock,
  input  logic             s_pllLocked,
  input  logic             ciReq,
  input  ciPkg::ciNumber_t ciN,
  input  ciPkg::ciWord_t   ciDataA,
  input  ciPkg::ciWord_t   ciDataB,
  output logic             ciAck,
  output ciPkg::ciWord_t   ciResult,
  output logic             systemReady
);

  logic s_reset;
  logic swapMode;

  ciUnitIf pixelBus ();
  ciUnitIf delayBus ();
  ciUnitIf profileBus ();

  resetSequencer #(
    .resetCycles(resetCycles)
  ) i_resetSequencer (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .systemReady  (systemReady),
    .s_reset      (s_reset)
  );

  ciDispatcher i_ciDispatcher (
    .s_systemClock(s_systemClock),
    .s_reset      (s_reset),
    .ciReq        (ciReq),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDataB      (ciDataB),
    .ciAck        (ciAck),
    .ciResult     (ciResult),
    .pixel        (pixelBus.dispatcher),
    .delay        (delayBus.dispatcher),
    .profile      (profileBus.dispatcher),
    .swapMode     (swapMode)
  );

  pixelUnit i_pixelUnit (
    .s_systemClock(s_systemClock),
    .s_reset      (s_reset),
    .unit         (pixelBus.unit),
    .swapMode     (swapMode)
  );

  delayUnit #(
    .delayWidth(delayWidth)
  ) i_delayUnit (
    .s_systemClock(s_systemClock),
    .s_reset      (s_reset),
    .unit         (delayBus.unit)
  );

  profileUnit i_profileUnit (
    .s_systemClock(s_systemClock),
    .s_reset      (s_reset),
    .unit         (profileBus.unit)
  );

endmodule

// ==== design/profileUnit.sv ====
`timescale 1ns/10ps

module profileUnit (
  input  logic  s_systemClock,
  input  logic  s_reset,
  ciUnitIf.unit unit
);

  ciPkg::ciWord_t cycleCount;
  ciPkg::ciWord_t resultReg;
  logic           doneReg;

  always_ff @(posedge s_systemClock or posedge s_reset) begin
    if (s_reset) begin
      cycleCount <= '0;
      doneReg    <= 1'b0;
    end else begin
      doneReg <= unit.start;
      if (unit.start && unit.dataB[0]) begin
        cycleCount <= '0; // the value read in this cycle is still returned.
      end else begin
        cycleCount <= cycleCount + 1'b1;
      end
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (unit.start) resultReg <= cycleCount;
  end

  assign unit.done   = doneReg;
  assign unit.result = doneReg ? resultReg : '0;

endmodule

// ==== design/delayUnit.sv ====
`timescale 1ns/10ps

module delayUnit #(
  parameter int delayWidth = 16
) (
  input  logic  s_systemClock,
  input  logic  s_reset,
  ciUnitIf.unit unit
);

  logic [delayWidth-1:0] loadValue;
  logic [delayWidth-1:0] delayCount;
  logic                  doneReg;

  assign loadValue = unit.dataA[delayWidth-1:0];

  // A count of N gives done N+1 cycles after start. A zero count answers on the next cycle.
  always_ff @(posedge s_systemClock or posedge s_reset) begin
    if (s_reset) begin
      delayCount <= '0;
      doneReg    <= 1'b0;
    end else begin
      doneReg <= 1'b0;
      if (unit.start) begin
        delayCount <= loadValue;
        doneReg    <= (loadValue == '0);
      end else if (delayCount != '0) begin
        delayCount <= delayCount - 1'b1;
        doneReg    <= (delayCount == delayWidth'(1)); // last step of the count.
      end
    end
  end

  assign unit.done   = doneReg;
  assign unit.result = '0;

endmodule

// ==== design/pixelUnit.sv ====
`timescale 1ns/10ps

module pixelUnit (
  input  logic   s_systemClock,
  input  logic   s_reset,
  ciUnitIf.unit  unit,
  input  logic   swapMode
);

  logic [1:0][7:0]        red8;
  logic [1:0][7:0]        green8;
  logic [1:0][7:0]        blue8;
  logic [1:0][2:0][15:0]  productReg; // index 1 is the high pixel.
  logic [1:0][15:0]       graySum;
  logic                   grayPending;
  logic                   doneReg;
  ciPkg::ciWord_t         swapped;
  ciPkg::ciWord_t         resultReg;

  assign swapped = {unit.dataA.bytes[0], unit.dataA.bytes[1],
                    unit.dataA.bytes[2], unit.dataA.bytes[3]};

  // widen every field to 8 bits, 5-bit fields by 3 and the 6-bit green by 2.
  assign red8[1]   = {unit.dataA.pixels.highRed, 3'b000};
  assign green8[1] = {unit.dataA.pixels.highGreen, 2'b00};
  assign blue8[1]  = {unit.dataA.pixels.highBlue, 3'b000};
  assign red8[0]   = {unit.dataA.pixels.lowRed, 3'b000};
  assign green8[0] = {unit.dataA.pixels.lowGreen, 2'b00};
  assign blue8[0]  = {unit.dataA.pixels.lowBlue, 3'b000};

  always_ff @(posedge s_systemClock) begin
    if (unit.start && !swapMode) begin
      for (int i = 0; i < 2; i++) begin
        productReg[i][0] <= red8[i] * ciPkg::GrayRedWeight;
        productReg[i][1] <= green8[i] * ciPkg::GrayGreenWeight;
        productReg[i][2] <= blue8[i] * ciPkg::GrayBlueWeight;
      end
    end
    if (unit.start && swapMode) begin
      resultReg <= swapped;
    end else if (grayPending) begin
      resultReg <= {16'h0000, graySum[1][15:8], graySum[0][15:8]};
    end
  end

  // the largest weighted sum stays below 2**16, so no carry is lost.
  assign graySum[1] = productReg[1][0] + productReg[1][1] + productReg[1][2];
  assign graySum[0] = productReg[0][0] + productReg[0][1] + productReg[0][2];

  always_ff @(posedge s_systemClock or posedge s_reset) begin
    if (s_reset) begin
      grayPending <= 1'b0;
      doneReg     <= 1'b0;
    end else begin
      grayPending <= unit.start && !swapMode;
      doneReg     <= (unit.start && swapMode) || grayPending; // swap 1 cycle, gray 2.
    end
  end

  assign unit.done   = doneReg;
  assign unit.result = doneReg ? resultReg : '0;

endmodule

// ==== design/ciDispatcher.sv ====
`timescale 1ns/10ps

module ciDispatcher (
  input  logic             s_systemClock,
  input  logic             s_reset,
  input  logic             ciReq,
  input  ciPkg::ciNumber_t ciN,
  input  ciPkg::ciWord_t   ciDataA,
  input  ciPkg::ciWord_t   ciDataB,
  output logic             ciAck,
  output ciPkg::ciWord_t   ciResult,
  ciUnitIf.dispatcher      pixel,
  ciUnitIf.dispatcher      delay,
  ciUnitIf.dispatcher      profile,
  output logic             swapMode
);

  localparam logic [1:0] Idle        = 2'd0;
  localparam logic [1:0] Busy        = 2'd1; // a unit runs, waiting for its done pulse.
  localparam logic [1:0] Acknowledge = 2'd2; // ack high, waiting for the host to drop ciReq.
  localparam logic [1:0] WaitRelease = 2'd3; // ciReq seen low, ack drops on the next edge.

  logic [1:0]        state;
  logic              ackReg;
  logic              startPixel;
  logic              startDelay;
  logic              startProfile;
  logic              swapReg;
  logic              selPixel;
  logic              selDelay;
  logic              selProfile;
  logic              accept;
  logic              unitDone;
  ciPkg::ciWord_t    unitResult;
  ciPkg::ciWord_t    resultReg;
  ciPkg::ciOperand_u opA;
  ciPkg::ciOperand_u opB;

  assign selPixel   = (ciN == ciPkg::CiSwapByte) || (ciN == ciPkg::CiGrayscale);
  assign selDelay   = (ciN == ciPkg::CiDelay);
  assign selProfile = (ciN == ciPkg::CiProfile);
  assign accept     = (state == Idle) && ciReq;

  // only the started unit answers, so a plain OR collects its done and result.
  assign unitDone   = pixel.done | delay.done | profile.done;
  assign unitResult = pixel.result | delay.result | profile.result;

  always_ff @(posedge s_systemClock or posedge s_reset) begin
    if (s_reset) begin
      state        <= Idle;
      ackReg       <= 1'b0;
      startPixel   <= 1'b0;
      startDelay   <= 1'b0;
      startProfile <= 1'b0;
    end else begin
      startPixel   <= accept && selPixel;
      startDelay   <= accept && selDelay;
      startProfile <= accept && selProfile;
      case (state)
        Idle: begin
          if (ciReq) begin
            if (selPixel || selDelay || selProfile) begin
              state <= Busy;
            end else begin
              state  <= Acknowledge; // unknown number, answer at once with zero.
              ackReg <= 1'b1;
            end
          end
        end
        Busy: begin
          if (unitDone) begin
            state  <= Acknowledge;
            ackReg <= 1'b1;
          end
        end
        Acknowledge: begin
          if (!ciReq) state <= WaitRelease;
        end
        default: begin
          state  <= Idle;
          ackReg <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (accept) begin
      opA     <= ciDataA;
      opB     <= ciDataB;
      swapReg <= (ciN == ciPkg::CiSwapByte);
    end
    if (accept && !(selPixel || selDelay || selProfile)) begin
      resultReg <= '0;
    end else if ((state == Busy) && unitDone) begin
      resultReg <= unitResult;
    end
  end

  assign pixel.start   = startPixel;
  assign pixel.dataA   = opA;
  assign pixel.dataB   = opB;
  assign delay.start   = startDelay;
  assign delay.dataA   = opA;
  assign delay.dataB   = opB;
  assign profile.start = startProfile;
  assign profile.dataA = opA;
  assign profile.dataB = opB;

  assign swapMode = swapReg;
  assign ciAck    = ackReg;
  assign ciResult = resultReg; // held until the next instruction is captured.

endmodule

// ==== design/resetSequencer.sv ====
`timescale 1ns/10ps

module resetSequencer #(
  parameter int resetCycles = 16
) (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic systemReady,
  output logic s_reset
);

  localparam int CountWidth = $clog2(resetCycles + 1);

  logic [CountWidth-1:0] lockCount;
  logic                  readyReg;

  // the counter stops once ready is set, so it never wraps.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      lockCount <= '0;
      readyReg  <= 1'b0;
    end else if (!readyReg) begin
      lockCount <= lockCount + 1'b1;
      readyReg  <= (lockCount == CountWidth'(resetCycles - 1)); // set on edge resetCycles.
    end
  end

  assign systemReady = readyReg;
  assign s_reset     = ~readyReg; // registered, so the internal reset is free of glitches.

endmodule

// ==== common/ciUnitIf.sv ====
`timescale 1ns/10ps

// Link between the dispatcher and one execution unit.
interface ciUnitIf;

  logic              start; // one-cycle pulse, operands valid in the same cycle.
  ciPkg::ciOperand_u dataA;
  ciPkg::ciOperand_u dataB;
  logic              done;  // exactly one pulse per start.
  ciPkg::ciWord_t    result; // zero outside the done cycle so results can be ORed.

  modport dispatcher (
    output start,
    output dataA,
    output dataB,
    input  done,
    input  result
  );

  modport unit (
    input  start,
    input  dataA,
    input  dataB,
    output done,
    output result
  );

endinterface

// ==== common/ciPkg.sv ====
package ciPkg;

  typedef logic [31:0] ciWord_t;   // operand or result word of a custom instruction.
  typedef logic [7:0]  ciNumber_t; // custom-instruction number.

  // One operand word decoded either as four bytes or as two RGB565 pixels.
  // The high pixel sits in bits 31:16 and the low pixel in bits 15:0.
  typedef union packed {
    logic [3:0][7:0] bytes;
    struct packed {
      logic [4:0] highRed;
      logic [5:0] highGreen;
      logic [4:0] highBlue;
      logic [4:0] lowRed;
      logic [5:0] lowGreen;
      logic [4:0] lowBlue;
    } pixels;
  } ciOperand_u;

  // instruction numbers decoded by the dispatcher.
  localparam ciNumber_t CiSwapByte  = 8'd1;
  localparam ciNumber_t CiDelay     = 8'd6;
  localparam ciNumber_t CiGrayscale = 8'd9;
  localparam ciNumber_t CiProfile   = 8'd12;

  // the three weights add up to 256, so the gray value is the top byte of the weighted sum.
  localparam logic [7:0] GrayRedWeight   = 8'd54;
  localparam logic [7:0] GrayGreenWeight = 8'd183;
  localparam logic [7:0] GrayBlueWeight  = 8'd19;

endpackage
